// ==== build.f ====
+incdir+.
rv_isa_pkg.sv
trace_pkg.sv
insn_decoder.sv
operand_resolver.sv
trace_fifo.sv
trace_ctrl.sv
rvfi_trace_top.sv
tb_rvfi_trace.sv

// ==== insn_decoder.sv ====
// ##########################################################
// Combinational RV32I/M classifier and access mask
// Compressed and unknown encodings report an empty mask
// ##########################################################
`include "trace_cfg.svh"

module insn_decoder (
  input  logic [`TRACE_XLEN-1:0]  insn,
  output rv_isa_pkg::insn_class_e insn_class,
  output rv_isa_pkg::access_t     access
);
  import rv_isa_pkg::*;

  rv_opcode_e opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       sys_plain;

  assign opcode = rv_opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // ECALL, EBREAK, MRET, DRET, WFI with rd, rs1 and funct3 all zero
  assign sys_plain = (insn[19:7] == 13'h0) &&
                     (insn[31:20] inside {12'h000, 12'h001, 12'h302, 12'h7b2, 12'h105});

  always_comb begin
    insn_class = CLS_INVALID;
    if (insn[1:0] != 2'b11) begin
      insn_class = CLS_COMPRESSED;
    end else begin
      case (opcode)
        LUI:    insn_class = CLS_LUI;
        AUIPC:  insn_class = CLS_AUIPC;
        JAL:    insn_class = CLS_JAL;
        JALR:   insn_class = (funct3 == 3'b000) ? CLS_JALR : CLS_INVALID;
        BRANCH: insn_class = (funct3[2:1] == 2'b01) ? CLS_INVALID : CLS_BRANCH;
        LOAD: begin
          insn_class = (funct3 inside {3'b011, 3'b110, 3'b111}) ? CLS_INVALID : CLS_LOAD;
        end
        STORE: begin
          insn_class = (funct3[2] || funct3[1:0] == 2'b11) ? CLS_INVALID : CLS_STORE;
        end
        OP_IMM: begin
          if (funct3 == 3'b001) begin
            insn_class = (funct7 == 7'b000_0000) ? CLS_SHIFT : CLS_INVALID;
          end else if (funct3 == 3'b101) begin
            // SRLI or SRAI
            insn_class = (funct7 inside {7'b000_0000, 7'b010_0000}) ? CLS_SHIFT : CLS_INVALID;
          end else begin
            insn_class = CLS_OPIMM;
          end
        end
        OP: begin
          if (funct7 == 7'b000_0001) begin
            insn_class = CLS_MULDIV;
          end else if (funct7 == 7'b000_0000) begin
            insn_class = CLS_OP;
          end else if (funct7 == 7'b010_0000 && funct3 inside {3'b000, 3'b101}) begin
            // SUB and SRA
            insn_class = CLS_OP;
          end
        end
        SYSTEM: begin
          if (funct3 == 3'b000) begin
            insn_class = sys_plain ? CLS_SYSTEM : CLS_INVALID;
          end else if (funct3 != 3'b100) begin
            insn_class = CLS_CSR;
          end
        end
        // FENCE and FENCE.I
        MISC_MEM: insn_class = (funct3[2:1] == 2'b00) ? CLS_FENCE : CLS_INVALID;
        default:  insn_class = CLS_INVALID;
      endcase
    end
  end

  always_comb begin
    access = '0;
    case (insn_class)
      CLS_OP, CLS_MULDIV: begin
        access.rs1 = 1'b1;
        access.rs2 = 1'b1;
        access.rd  = 1'b1;
      end
      CLS_OPIMM, CLS_SHIFT, CLS_JALR: begin
        access.rs1 = 1'b1;
        access.rd  = 1'b1;
      end
      CLS_LUI, CLS_AUIPC, CLS_JAL: access.rd = 1'b1;
      CLS_BRANCH: begin
        access.rs1 = 1'b1;
        access.rs2 = 1'b1;
      end
      CLS_LOAD: begin
        access.rs1 = 1'b1;
        access.rd  = 1'b1;
        access.mem = 1'b1;
      end
      CLS_STORE: begin
        access.rs1 = 1'b1;
        access.rs2 = 1'b1;
        access.mem = 1'b1;
      end
      CLS_CSR: begin
        // Immediate forms carry a uimm in the rs1 field
        access.rd  = 1'b1;
        access.rs1 = !funct3[2];
      end
      default: access = '0;
    endcase
  end

  // Nothing outside the decoded RV32I/M set may claim a resource
  mask_empty_a: assert final (!(insn_class inside {CLS_COMPRESSED, CLS_INVALID}) ||
                              access == '0);

endmodule

// ==== operand_resolver.sv ====
// ##########################################################
// Combinational operand word per instruction class
// LUI/AUIPC give the raw 20-bit field, not shifted
// ##########################################################
`include "trace_cfg.svh"

module operand_resolver (
  input  logic [`TRACE_XLEN-1:0]  insn,
  input  rv_isa_pkg::insn_class_e insn_class,
  input  logic [`TRACE_XLEN-1:0]  pc_rdata,
  input  logic [`TRACE_XLEN-1:0]  pc_wdata,
  output logic [`TRACE_XLEN-1:0]  operand
);
  import rv_isa_pkg::*;

  localparam int xlen = `TRACE_XLEN;

  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;

  assign imm_i = {{(xlen-12){insn[31]}}, insn[31:20]};
  assign imm_s = {{(xlen-12){insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{(xlen-13){insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};

  always_comb begin
    case (insn_class)
      CLS_OPIMM, CLS_LOAD, CLS_JALR: operand = imm_i;
      CLS_SHIFT:                     operand = xlen'(insn[24:20]);
      CLS_STORE:                     operand = imm_s;
      CLS_LUI, CLS_AUIPC:            operand = xlen'(insn[31:12]);
      // Jump target is whatever the core retired as next pc
      CLS_JAL:                       operand = pc_wdata;
      // Taken-branch target, independent of the actual outcome
      CLS_BRANCH:                    operand = pc_rdata + imm_b;
      CLS_CSR:                       operand = xlen'(insn[31:20]);
      // Predecessor and successor sets
      CLS_FENCE:                     operand = xlen'(insn[27:20]);
      default:                       operand = '0;
    endcase
  end

endmodule

// ==== rv_isa_pkg.sv ====
// ##########################################################
// RV32I/M decode types used by the trace datapath
// Compressed encodings are only recognised, never decoded
// ##########################################################
package rv_isa_pkg;

  // Major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    LOAD     = 7'b000_0011,
    MISC_MEM = 7'b000_1111,
    OP_IMM   = 7'b001_0011,
    AUIPC    = 7'b001_0111,
    STORE    = 7'b010_0011,
    OP       = 7'b011_0011,
    LUI      = 7'b011_0111,
    BRANCH   = 7'b110_0011,
    JALR     = 7'b110_0111,
    JAL      = 7'b110_1111,
    SYSTEM   = 7'b111_0011
  } rv_opcode_e;

  // Instruction class as reported in info[5:0]
  typedef enum logic [5:0] {
    CLS_INVALID    = 6'd0,
    CLS_COMPRESSED = 6'd1,
    CLS_LUI        = 6'd2,
    CLS_AUIPC      = 6'd3,
    CLS_JAL        = 6'd4,
    CLS_JALR       = 6'd5,
    CLS_BRANCH     = 6'd6,
    CLS_LOAD       = 6'd7,
    CLS_STORE      = 6'd8,
    CLS_OPIMM      = 6'd9,
    CLS_SHIFT      = 6'd10,
    CLS_OP         = 6'd11,
    CLS_MULDIV     = 6'd12,
    CLS_CSR        = 6'd13,
    CLS_SYSTEM     = 6'd14,
    CLS_FENCE      = 6'd15
  } insn_class_e;

  // Resources touched by one instruction
  // rs1 sits in bit 0 and mem in bit 3 of the packed value
  typedef struct packed {
    logic mem;
    logic rd;
    logic rs2;
    logic rs1;
  } access_t;

endpackage

// ==== rvfi_trace_top.sv ====
// ##########################################################
// RVFI trace encoder top with a Wishbone master toward sink
// No back-pressure to the core; overflow drops and flags
// ##########################################################
`include "trace_cfg.svh"

module rvfi_trace_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  trace_pkg::retire_t  rvfi,
  output trace_pkg::wb_req_t  wb,
  input  logic                wb_ack
);
  import rv_isa_pkg::*;
  import trace_pkg::*;

  insn_class_e            insn_class;
  access_t                access;
  logic [`TRACE_XLEN-1:0] operand;
  trace_rec_t             rec;
  logic                   push;
  trace_rec_t             push_rec;
  logic                   pop;
  trace_rec_t             head;
  logic                   empty;
  logic                   full;

  insn_decoder u_decoder (
    .insn       (rvfi.insn),
    .insn_class (insn_class),
    .access     (access)
  );

  operand_resolver u_resolver (
    .insn       (rvfi.insn),
    .insn_class (insn_class),
    .pc_rdata   (rvfi.pc_rdata),
    .pc_wdata   (rvfi.pc_wdata),
    .operand    (operand)
  );

  // Cycle stamp and lost flag are filled in by the controller
  always_comb begin
    rec         = '0;
    rec.pc      = rvfi.pc_rdata;
    rec.insn    = rvfi.insn;
    rec.operand = operand;
    rec.info    = {6'b0, 1'b0, rvfi.rs2_addr, rvfi.rs1_addr, rvfi.rd_addr, access, insn_class};
  end

  trace_ctrl u_ctrl (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid    (rvfi.valid),
    .rec_in   (rec),
    .push     (push),
    .push_rec (push_rec),
    .full     (full),
    .empty    (empty),
    .head     (head),
    .pop      (pop),
    .wb       (wb),
    .wb_ack   (wb_ack)
  );

  trace_fifo u_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .push     (push),
    .push_rec (push_rec),
    .pop      (pop),
    .head     (head),
    .empty    (empty),
    .full     (full)
  );

endmodule

// ==== tb_rvfi_trace.sv ====
// ##########################################################
// Self-checking testbench for the RVFI trace encoder
// Sink model acks single writes, optionally after a delay
// ##########################################################
`include "trace_cfg.svh"

module tb_rvfi_trace;
  timeunit 1ns;
  timeprecision 1ps;

  import rv_isa_pkg::*;
  import trace_pkg::*;

  localparam int depth         = `TRACE_FIFO_DEPTH;
  localparam int words         = `TRACE_REC_WORDS;
  localparam int max_delay     = 3;
  localparam int rec_cycles    = words * (2 + max_delay) + 2;
  localparam int n_items       = 21 + 9 + 6 + depth + 6;
  localparam int n_rand_cycles = 150;
  localparam int limit         = 20 * (10 + (n_items + n_rand_cycles) * rec_cycles);

  logic    clk_i  = 1'b0;
  logic    rst_ni = 1'b0;
  retire_t rvfi   = '0;
  wb_req_t wb;
  logic    wb_ack = 1'b0;

  trace_rec_t  exp_q[$];
  trace_rec_t  rx_q[$];
  logic [31:0] rx_words [words];
  int          edge_cnt;
  int          accepted;
  int          popped;
  int          word_idx;
  int          wait_cnt;
  int          cyc_cnt;
  int          err_cnt;
  int          n_checked;
  int          n_dropped;
  int          mark_err;
  int          mark_rec;
  int          mark_drop;
  logic        lost_pending = 1'b0;
  logic        gap_chk      = 1'b0;
  logic        hold_ack     = 1'b0;
  logic        rand_delay   = 1'b0;
  logic [31:0] stim_seed    = 32'h225d_c7db;
  logic [31:0] ack_seed     = 32'h225d_c7db;

  logic [6:0]  opcodes [12] = '{7'h03, 7'h0f, 7'h13, 7'h17, 7'h23, 7'h33,
                                7'h37, 7'h63, 7'h67, 7'h6f, 7'h73, 7'h33};
  logic [31:0] class_list [] = '{32'h123450b7, 32'hfffff117, 32'h100000ef, 32'h000280e7,
                                 32'hfe208e63, 32'h00419863, 32'hffc42383, 32'h00014083,
                                 32'h00952423, 32'hfe110823, 32'hfff30293, 32'h00731293,
                                 32'h41f35293, 32'h002081b3, 32'h402081b3, 32'h022081b3,
                                 32'h0220d1b3, 32'h300110f3, 32'hb002e1f3, 32'h00000073,
                                 32'h0ff0000f};
  // Compressed forms first and reserved encodings after
  logic [31:0] bad_list [] = '{32'h00004501, 32'h00008082, 32'h00000000, 32'h00003083,
                               32'h00004023, 32'h0000007f, 32'h40001033, 32'h00004073,
                               32'h00001067};

  rvfi_trace_top UUT (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .rvfi   (rvfi),
    .wb     (wb),
    .wb_ack (wb_ack)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= limit) begin
      $display("Timeout after %0d cycles, records still pending in the DUT", cyc_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Standard RV32I/M decode from the ISA tables
  function automatic insn_class_e classify(input logic [31:0] insn);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = insn[14:12];
    f7 = insn[31:25];
    if (insn[1:0] != 2'b11) return CLS_COMPRESSED;
    case (insn[6:0])
      7'h37: return CLS_LUI;
      7'h17: return CLS_AUIPC;
      7'h6f: return CLS_JAL;
      7'h67: return (f3 == 3'd0) ? CLS_JALR : CLS_INVALID;
      7'h63: return (f3 == 3'd2 || f3 == 3'd3) ? CLS_INVALID : CLS_BRANCH;
      7'h03: return (f3 == 3'd3 || f3 >= 3'd6) ? CLS_INVALID : CLS_LOAD;
      7'h23: return (f3 > 3'd2) ? CLS_INVALID : CLS_STORE;
      7'h13: begin
        if (f3 == 3'd1) return (f7 == 7'h00) ? CLS_SHIFT : CLS_INVALID;
        if (f3 == 3'd5) return (f7 == 7'h00 || f7 == 7'h20) ? CLS_SHIFT : CLS_INVALID;
        return CLS_OPIMM;
      end
      7'h33: begin
        if (f7 == 7'h01) return CLS_MULDIV;
        if (f7 == 7'h00) return CLS_OP;
        return (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)) ? CLS_OP : CLS_INVALID;
      end
      7'h73: begin
        if (f3 == 3'd4) return CLS_INVALID;
        if (f3 != 3'd0) return CLS_CSR;
        // ECALL, EBREAK, WFI, MRET, DRET
        if (insn[19:7] == 13'h0 && (insn[31:20] == 12'h000 || insn[31:20] == 12'h001 ||
            insn[31:20] == 12'h105 || insn[31:20] == 12'h302 || insn[31:20] == 12'h7b2))
          return CLS_SYSTEM;
        return CLS_INVALID;
      end
      7'h0f: return (f3 <= 3'd1) ? CLS_FENCE : CLS_INVALID;
      default: return CLS_INVALID;
    endcase
  endfunction

  // Bits are mem, rd, rs2, rs1 from high to low
  function automatic logic [3:0] mask_of(input insn_class_e cls, input logic [31:0] insn);
    case (cls)
      CLS_OP, CLS_MULDIV:             return 4'b0111;
      CLS_OPIMM, CLS_SHIFT, CLS_JALR: return 4'b0101;
      CLS_LUI, CLS_AUIPC, CLS_JAL:    return 4'b0100;
      CLS_BRANCH:                     return 4'b0011;
      CLS_LOAD:                       return 4'b1101;
      CLS_STORE:                      return 4'b1011;
      CLS_CSR:                        return {3'b010, !insn[14]};
      default:                        return 4'b0000;
    endcase
  endfunction

  function automatic logic [31:0] operand_of(input insn_class_e cls, input retire_t r);
    logic [31:0] i;
    i = r.insn;
    case (cls)
      CLS_OPIMM, CLS_LOAD, CLS_JALR: return {{20{i[31]}}, i[31:20]};
      CLS_SHIFT:          return {27'b0, i[24:20]};
      CLS_STORE:          return {{20{i[31]}}, i[31:25], i[11:7]};
      CLS_LUI, CLS_AUIPC: return {12'b0, i[31:12]};
      CLS_JAL:            return r.pc_wdata;
      CLS_BRANCH:         return r.pc_rdata + {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
      CLS_CSR:            return {20'b0, i[31:20]};
      CLS_FENCE:          return {24'b0, i[27:20]};
      default:            return 32'h0;
    endcase
  endfunction

  function automatic trace_rec_t expect_rec(input retire_t r, input logic [31:0] stamp,
                                            input logic lost);
    trace_rec_t  e;
    insn_class_e cls;
    cls       = classify(r.insn);
    e.cycle   = stamp;
    e.pc      = r.pc_rdata;
    e.insn    = r.insn;
    e.operand = operand_of(cls, r);
    e.info    = {6'b0, lost, r.rs2_addr, r.rs1_addr, r.rd_addr, mask_of(cls, r.insn), cls};
    return e;
  endfunction

  // Retirement monitor, FIFO occupancy model and Wishbone sink
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (rvfi.valid) begin
        if (accepted - popped >= depth) begin
          n_dropped++;
          lost_pending = 1'b1;
        end else begin
          exp_q.push_back(expect_rec(rvfi, edge_cnt, lost_pending));
          lost_pending = 1'b0;
          accepted++;
        end
      end
      edge_cnt++;
      if (gap_chk) begin
        check_value("wb.cyc after record", wb.cyc, 1'b0);
        check_value("wb.stb after record", wb.stb, 1'b0);
        gap_chk = 1'b0;
      end
      if (wb.cyc && wb.stb && wb_ack) begin
        check_value("wb.adr", wb.adr, `TRACE_BASE_ADDR + 32'(4 * word_idx));
        check_value("wb.we", wb.we, 1'b1);
        check_value("wb.sel", wb.sel, 4'hf);
        rx_words[word_idx] = wb.dat;
        word_idx++;
        if (word_idx == words) begin
          rx_q.push_back({rx_words[0], rx_words[1], rx_words[2], rx_words[3], rx_words[4]});
          popped++;
          word_idx = 0;
          gap_chk  = 1'b1;
        end
      end
      if (wb_ack) begin
        wb_ack <= 1'b0;
      end else if (wb.stb && !hold_ack) begin
        if (wait_cnt == 0) begin
          wb_ack <= 1'b1;
          if (rand_delay) begin
            ack_seed = xorshift32(ack_seed);
            wait_cnt = ack_seed % (max_delay + 1);
          end
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  // Scoreboard in arrival order
  always @(negedge clk_i) begin
    trace_rec_t got;
    trace_rec_t exp;
    while (rx_q.size() > 0) begin
      got = rx_q.pop_front();
      if (exp_q.size() == 0) begin
        $display("Unexpected record at %0t: sink got a record with no retirement pending",
                 $time);
        err_cnt++;
      end else begin
        exp = exp_q.pop_front();
        check_value("record.cycle", got.cycle, exp.cycle);
        check_value("record.pc", got.pc, exp.pc);
        check_value("record.insn", got.insn, exp.insn);
        check_value("record.operand", got.operand, exp.operand);
        check_value("record.info", got.info, exp.info);
        n_checked++;
      end
    end
  end

  task automatic next_stim(output logic [31:0] v);
    stim_seed = xorshift32(stim_seed);
    v = stim_seed;
  endtask

  task automatic retire(input logic [31:0] insn, input logic [31:0] pc,
                        input logic [31:0] pc_next);
    retire_t r;
    r.valid    = 1'b1;
    r.insn     = insn;
    r.rs1_addr = insn[19:15];
    r.rs2_addr = insn[24:20];
    r.rd_addr  = insn[11:7];
    r.pc_rdata = pc;
    r.pc_wdata = pc_next;
    @(posedge clk_i);
    rvfi <= r;
    @(posedge clk_i);
    rvfi.valid <= 1'b0;
  endtask

  task automatic wait_drain();
    do begin
      @(negedge clk_i);
    end while (exp_q.size() != 0 || rx_q.size() != 0 || wb.cyc || rvfi.valid || gap_chk);
  endtask

  task automatic finish_test(input string name);
    $display("test %-8s done: %0d records, %0d dropped, %0d errors", name,
             n_checked - mark_rec, n_dropped - mark_drop, err_cnt - mark_err);
    mark_rec  = n_checked;
    mark_drop = n_dropped;
    mark_err  = err_cnt;
  endtask

  task automatic drive_list(input string name, input logic [31:0] list []);
    logic [31:0] pc;
    for (int k = 0; k < list.size(); k++) begin
      pc = 32'h0000_0100 + 32'(4 * k);
      retire(list[k], pc, pc ^ 32'h0000_0f00);
      if (k % 5 == 4) wait_drain();
    end
    wait_drain();
    finish_test(name);
  endtask

  task automatic stamp_gaps();
    int gaps [6] = '{0, 1, 3, 7, 2, 12};
    for (int k = 0; k < 6; k++) begin
      repeat (gaps[k]) @(posedge clk_i);
      retire(32'h0010_0093, 32'h200 + 32'(4 * k), 32'h204 + 32'(4 * k));
    end
    wait_drain();
    finish_test("delta");
  endtask

  task automatic flood_fifo();
    int rx0;
    int popped0;
    hold_ack = 1'b1;
    rx0      = popped;
    for (int k = 0; k < depth + 4; k++) begin
      retire(32'h0000_0013 | 32'(k << 7), 32'h300 + 32'(4 * k), 32'h304 + 32'(4 * k));
    end
    popped0 = popped;
    @(negedge clk_i);
    hold_ack = 1'b0;
    // One slot frees up once the head record is through
    while (popped == popped0) @(negedge clk_i);
    retire(32'h00a0_0513, 32'h400, 32'h404);
    wait_drain();
    retire(32'h00b0_0593, 32'h404, 32'h408);
    wait_drain();
    // Only the records that fitted, plus the two sent after the loss
    check_value("records out", popped - rx0, depth + 2);
    finish_test("overflow");
  endtask

  task automatic random_traffic(input int n_cycles);
    retire_t     r;
    logic [31:0] w;
    logic [31:0] s;
    rand_delay = 1'b1;
    for (int k = 0; k < n_cycles; k++) begin
      next_stim(w);
      next_stim(s);
      r.insn = {w[31:7], opcodes[s[3:0] % 12]};
      if (s[4]) r.insn[31:25] = {6'b0, s[5]};
      if (s[8:6] == 3'b000) r.insn[1:0] = {s[9], 1'b0};
      r.valid    = (s[11:10] == 2'b00);
      r.rs1_addr = s[16:12];
      r.rs2_addr = s[21:17];
      r.rd_addr  = s[26:22];
      next_stim(w);
      r.pc_rdata = {w[31:2], 2'b00};
      r.pc_wdata = r.pc_rdata + {{20{s[31]}}, s[31:22], 2'b00};
      @(posedge clk_i);
      rvfi <= r;
    end
    @(posedge clk_i);
    rvfi.valid <= 1'b0;
    wait_drain();
    rand_delay = 1'b0;
    finish_test("random");
  endtask

  initial begin
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_value("wb.cyc after reset", wb.cyc, 1'b0);
    check_value("wb.stb after reset", wb.stb, 1'b0);
    drive_list("classes", class_list);
    drive_list("illegal", bad_list);
    stamp_gaps();
    flood_fifo();
    random_traffic(n_rand_cycles);
    $display("Summary: %0d records checked, %0d dropped, %0d errors",
             n_checked, n_dropped, err_cnt);
    if (err_cnt == 0 && exp_q.size() == 0 && n_checked > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== trace_cfg.svh ====
// ##########################################################
// Build settings shared by the trace encoder and testbench
// The record layout assumes TRACE_XLEN stays at 32 (RV32)
// ##########################################################
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// Data and address width, one bus word
`define TRACE_XLEN 32

// Records held while the sink is busy
`define TRACE_FIFO_DEPTH 8

// Bus words per trace record
`define TRACE_REC_WORDS 5

// Sink address of record word 0, word k lands at base plus 4k
`define TRACE_BASE_ADDR 32'h1000_0000

`endif

// ==== trace_ctrl.sv ====
// ##########################################################
// Stamps, queues and serialises records onto Wishbone
// Single classic writes, cyc drops after every record
// ##########################################################
`include "trace_cfg.svh"

module trace_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid,
  input  trace_pkg::trace_rec_t rec_in,
  output logic                  push,
  output trace_pkg::trace_rec_t push_rec,
  input  logic                  full,
  input  logic                  empty,
  input  trace_pkg::trace_rec_t head,
  output logic                  pop,
  output trace_pkg::wb_req_t    wb,
  input  logic                  wb_ack
);
  import trace_pkg::*;

  localparam int xlen      = `TRACE_XLEN;
  localparam int rec_words = `TRACE_REC_WORDS;
  localparam int idx_w     = $clog2(rec_words);
  localparam int lost_bit  = 25;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    GAP
  } state_e;

  state_e           state_q;
  state_e           state_d;
  logic [idx_w-1:0] idx_q;
  logic [idx_w-1:0] idx_d;
  logic [xlen-1:0]  cycle_q;
  logic             lost_q;
  logic             last_word;

  // Free-running count of edges since reset release
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
    end
  end

  // Retirements arriving while full are dropped
  assign push = valid && !full;

  always_comb begin
    push_rec                = rec_in;
    push_rec.cycle          = cycle_q;
    push_rec.info[lost_bit] = lost_q;
  end

  // Pending loss until the next record that makes it in
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lost_q <= 1'b0;
    end else if (valid && full) begin
      lost_q <= 1'b1;
    end else if (push) begin
      lost_q <= 1'b0;
    end
  end

  assign last_word = (idx_q == idx_w'(rec_words - 1));
  assign pop       = (state_q == SEND) && wb_ack && last_word;

  always_comb begin
    state_d = state_q;
    idx_d   = idx_q;
    case (state_q)
      IDLE: begin
        if (!empty) begin
          state_d = SEND;
          idx_d   = '0;
        end
      end
      SEND: begin
        if (wb_ack) begin
          if (last_word) begin
            state_d = GAP;
          end else begin
            idx_d = idx_q + 1'b1;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
    end
  end

  always_comb begin
    wb.cyc = (state_q == SEND);
    wb.stb = (state_q == SEND);
    wb.we  = 1'b1;
    wb.sel = '1;
    wb.adr = xlen'(`TRACE_BASE_ADDR) + (xlen'(idx_q) << 2);
    case (idx_q)
      3'd0:    wb.dat = head.cycle;
      3'd1:    wb.dat = head.pc;
      3'd2:    wb.dat = head.insn;
      3'd3:    wb.dat = head.operand;
      default: wb.dat = head.info;
    endcase
  end

  // The head record must not move under an outstanding write
  wb_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb.stb && !wb_ack |=> $stable(wb.adr) && $stable(wb.dat));

endmodule

// ==== trace_fifo.sv ====
// ##########################################################
// Circular record buffer of TRACE_FIFO_DEPTH entries
// Caller must not push when full nor pop when empty
// ##########################################################
`include "trace_cfg.svh"

module trace_fifo (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  push,
  input  trace_pkg::trace_rec_t push_rec,
  input  logic                  pop,
  output trace_pkg::trace_rec_t head,
  output logic                  empty,
  output logic                  full
);
  import trace_pkg::*;

  localparam int depth = `TRACE_FIFO_DEPTH;
  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);

  trace_rec_t       mem [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;

  // Wrap explicitly so a depth that is not a power of two still works
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head  = mem[rd_ptr_q];
  assign empty = (count_q == '0);
  assign full  = (count_q == cnt_w'(depth));

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= push_rec;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Overflow and underflow are the controller's job to prevent
  push_not_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni) push |-> !full);
  pop_not_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni) pop |-> !empty);

endmodule

// ==== trace_pkg.sv ====
// ##########################################################
// Transport types: retirement input, record, Wishbone req
// Only the RVFI fields the encoder needs are carried
// ##########################################################
`include "trace_cfg.svh"

package trace_pkg;

  // One retirement as seen on the core's RVFI port
  typedef struct packed {
    logic                   valid;
    logic [`TRACE_XLEN-1:0] insn;
    logic [4:0]             rs1_addr;
    logic [4:0]             rs2_addr;
    logic [4:0]             rd_addr;
    logic [`TRACE_XLEN-1:0] pc_rdata;
    logic [`TRACE_XLEN-1:0] pc_wdata;
  } retire_t;

  // Five-word record, sent in declaration order
  // info: [5:0] class, [9:6] mask, [14:10] rd, [19:15] rs1,
  // [24:20] rs2, [25] lost, upper bits zero
  typedef struct packed {
    logic [`TRACE_XLEN-1:0] cycle;
    logic [`TRACE_XLEN-1:0] pc;
    logic [`TRACE_XLEN-1:0] insn;
    logic [`TRACE_XLEN-1:0] operand;
    logic [`TRACE_XLEN-1:0] info;
  } trace_rec_t;

  // Wishbone classic master request
  typedef struct packed {
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`TRACE_XLEN-1:0]   adr;
    logic [`TRACE_XLEN-1:0]   dat;
    logic [`TRACE_XLEN/8-1:0] sel;
  } wb_req_t;

endpackage
